/* rtl/game_defines.svh */
`ifndef GAME_DEFINES_SVH
`define GAME_DEFINES_SVH

// entries in the target buffer, power of two
`define TARGET_FIFO_DEPTH 4

// countdown steps shown per memorize phase
`define COUNT_START 3

// clock cycles per countdown step (one second on the board)
`define TICKS_PER_STEP 4

// beeper hold after a wrong guess, in cycles
`define BEEP_CYCLES 8

// must be nonzero or the lfsr locks up
`define LFSR_SEED 7'h5A

`endif

/* rtl/target_pkg.sv */
`default_nettype none

package target_pkg;

    // one target as shown on the leds and set on the switches
    typedef logic [6:0] target_t;

    typedef enum logic [1:0]
    {
        LVL_NONE,
        LVL_1,
        LVL_2,
        LVL_3
    } level_e;

    // number of low target bits a level compares
    function automatic logic [2:0] level_width(level_e lvl);
        case (lvl)
            LVL_1:   return 3'd5;
            LVL_2:   return 3'd6;
            LVL_3:   return 3'd7;
            default: return 3'd0;
        endcase
    endfunction

endpackage

`default_nettype wire

/* rtl/game_state_pkg.sv */
`default_nettype none

package game_state_pkg;

    // controller states of the memory game
    typedef enum logic [2:0]
    {
        ST_OFF,
        ST_READY,
        ST_FETCH,
        ST_SHOW,
        ST_WAIT,
        ST_JUDGE,
        ST_WIN
    } game_state_e;

endpackage

`default_nettype wire

/* rtl/target_if.sv */
`timescale 1ns/1ps
`default_nettype none

// target stream from the buffer to the game controller
interface target_if;

    logic                valid;
    target_pkg::target_t target;
    logic                ready;
    logic                flush;

    modport buffer
    (
        output valid,
        output target,
        input  ready,
        input  flush
    );

    modport consumer
    (
        input  valid,
        input  target,
        output ready,
        output flush
    );

endinterface

`default_nettype wire

/* rtl/target_lfsr.sv */
`timescale 1ns/1ps
`default_nettype none

`include "game_defines.svh"

module target_lfsr
(
    input  wire                 clk,
    input  wire                 sw,
    output logic                push_valid,
    input  logic                push_ready,
    output target_pkg::target_t push_target
);

    target_pkg::target_t lfsr_q;
    logic                valid_q;

    // x^7 + x^6 + 1, feedback from bits 6 and 5
    always_ff @(posedge clk or posedge sw)
    begin
        if (sw)
        begin
            lfsr_q <= `LFSR_SEED;
        end
        else if (push_valid && push_ready)
        begin
            lfsr_q <= {lfsr_q[5:0], lfsr_q[6] ^ lfsr_q[5]};
        end
    end

    // producer always has a target once out of reset
    always_ff @(posedge clk or posedge sw)
    begin
        if (sw)
            valid_q <= 1'b0;
        else
            valid_q <= 1'b1;
    end

    assign push_valid  = valid_q;
    assign push_target = lfsr_q;

    a_lfsr_nonzero: assert property (@(posedge clk) disable iff (sw) lfsr_q != '0)
        else $error("lfsr reached the all-zero lock-up state");

endmodule

`default_nettype wire

/* rtl/target_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

`include "game_defines.svh"

module target_fifo
(
    input  wire                 clk,
    input  wire                 sw,
    input  logic                push_valid,
    output logic                push_ready,
    input  target_pkg::target_t push_target,
    target_if.buffer            pop
);

    localparam int DEPTH = `TARGET_FIFO_DEPTH;
    localparam int PW    = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    target_pkg::target_t mem [DEPTH];
    logic [PW-1:0]       wr_ptr_q;
    logic [PW-1:0]       rd_ptr_q;
    logic [PW:0]         count_q;
    logic                do_push;
    logic                do_pop;

    // no push while flushing so the producer keeps its value
    assign push_ready = (count_q != (PW+1)'(DEPTH)) && !pop.flush;
    assign do_push    = push_valid && push_ready;

    assign pop.valid  = (count_q != '0);
    assign pop.target = mem[rd_ptr_q];
    assign do_pop     = pop.valid && pop.ready;

    always_ff @(posedge clk)
    begin
        if (do_push)
            mem[wr_ptr_q] <= push_target;
    end

    always_ff @(posedge clk or posedge sw)
    begin
        if (sw)
        begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end
        else if (pop.flush)
        begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end
        else
        begin
            if (do_push)
                wr_ptr_q <= wr_ptr_q + 1'b1;
            if (do_pop)
                rd_ptr_q <= rd_ptr_q + 1'b1;
            // simultaneous push and pop leaves the count alone
            if (do_push && !do_pop)
                count_q <= count_q + 1'b1;
            else if (do_pop && !do_push)
                count_q <= count_q - 1'b1;
        end
    end

    a_count_range: assert property (@(posedge clk) disable iff (sw)
        count_q <= (PW+1)'(DEPTH))
        else $error("target fifo count out of range");

    a_push_empty: assert property (@(posedge clk) disable iff (sw)
        (count_q == '0 && do_push && !pop.flush) |=> pop.valid)
        else $error("target fifo not valid after push into empty buffer");

endmodule

`default_nettype wire

/* rtl/round_timer.sv */
`timescale 1ns/1ps
`default_nettype none

`include "game_defines.svh"

module round_timer
(
    input  wire         clk,
    input  wire         sw,
    input  logic        load,
    output logic [3:0]  count,
    output logic        expired
);

    localparam int TW = (`TICKS_PER_STEP > 1) ? $clog2(`TICKS_PER_STEP) : 1;

    logic [TW-1:0] presc_q;
    logic [3:0]    count_q;
    logic          step;

    // one countdown step per prescaler wrap, only while counting
    assign step    = (count_q != '0) && (presc_q == TW'(`TICKS_PER_STEP - 1));
    assign expired = step && (count_q == 4'd1);
    assign count   = count_q;

    always_ff @(posedge clk or posedge sw)
    begin
        if (sw)
        begin
            count_q <= '0;
            presc_q <= '0;
        end
        else if (load)
        begin
            count_q <= 4'(`COUNT_START);
            presc_q <= '0;
        end
        else if (step)
        begin
            count_q <= count_q - 1'b1;
            presc_q <= '0;
        end
        else if (count_q != '0)
        begin
            presc_q <= presc_q + 1'b1;
        end
    end

    // timer parks at zero until reloaded
    a_expire_once: assert property (@(posedge clk) disable iff (sw)
        (expired && !load) |=> (count_q == '0) && !expired)
        else $error("round timer kept running after expiry");

endmodule

`default_nettype wire

/* rtl/game_fsm.sv */
`timescale 1ns/1ps
`default_nettype none

`include "game_defines.svh"

module game_fsm
(
    input  wire                  clk,
    input  wire                  sw,
    input  logic                 enable,
    input  logic                 start,
    input  logic                 restart,
    input  target_pkg::target_t  guess,
    target_if.consumer           pull,
    output logic                 timer_load,
    input  logic                 timer_expired,
    output logic [15:0]          led,
    output target_pkg::level_e   level,
    output logic                 beep,
    output logic                 victory
);

    localparam int BW = $clog2(`BEEP_CYCLES + 1);

    game_state_pkg::game_state_e state_q;
    target_pkg::level_e          level_q;
    target_pkg::target_t         target_q;
    target_pkg::target_t         lvl_mask;
    logic [BW-1:0]               beep_cnt_q;
    logic                        match;
    logic                        judge_fail;

    // low bits compared at the current level
    always_comb
    begin
        for (int i = 0; i < 7; i++)
            lvl_mask[i] = (i < int'(target_pkg::level_width(level_q)));
    end

    assign match      = ((guess ^ target_q) & lvl_mask) == '0;
    assign judge_fail = enable && (state_q == game_state_pkg::ST_JUDGE) && !match;

    // pop and timer load share the fetch handshake
    assign pull.ready = enable && (state_q == game_state_pkg::ST_FETCH);
    assign timer_load = pull.ready && pull.valid;
    // lasts one cycle since the next state is off
    assign pull.flush = !enable && (state_q != game_state_pkg::ST_OFF);

    assign led     = (state_q == game_state_pkg::ST_SHOW) ? {9'b0, target_q & lvl_mask} : '0;
    assign level   = level_q;
    assign beep    = (beep_cnt_q != '0);
    assign victory = (state_q == game_state_pkg::ST_WIN);

    always_ff @(posedge clk or posedge sw)
    begin
        if (sw)
        begin
            state_q <= game_state_pkg::ST_OFF;
            level_q <= target_pkg::LVL_NONE;
        end
        else if (!enable)
        begin
            state_q <= game_state_pkg::ST_OFF;
            level_q <= target_pkg::LVL_NONE;
        end
        else
        begin
            case (state_q)
                game_state_pkg::ST_OFF:
                begin
                    state_q <= game_state_pkg::ST_READY;
                end
                game_state_pkg::ST_READY:
                begin
                    if (start)
                    begin
                        state_q <= game_state_pkg::ST_FETCH;
                        level_q <= target_pkg::LVL_1;
                    end
                end
                game_state_pkg::ST_FETCH:
                begin
                    if (pull.valid)
                        state_q <= game_state_pkg::ST_SHOW;
                end
                game_state_pkg::ST_SHOW:
                begin
                    if (restart)
                    begin
                        state_q <= game_state_pkg::ST_FETCH;
                        level_q <= target_pkg::LVL_1;
                    end
                    else if (timer_expired)
                    begin
                        state_q <= game_state_pkg::ST_WAIT;
                    end
                end
                game_state_pkg::ST_WAIT:
                begin
                    if (restart)
                    begin
                        state_q <= game_state_pkg::ST_FETCH;
                        level_q <= target_pkg::LVL_1;
                    end
                    else if (start)
                    begin
                        state_q <= game_state_pkg::ST_JUDGE;
                    end
                end
                game_state_pkg::ST_JUDGE:
                begin
                    // a miss replays the same level
                    if (match && level_q == target_pkg::LVL_3)
                        state_q <= game_state_pkg::ST_WIN;
                    else
                        state_q <= game_state_pkg::ST_FETCH;
                    if (match && level_q != target_pkg::LVL_3)
                        level_q <= target_pkg::level_e'(level_q + 2'd1);
                end
                game_state_pkg::ST_WIN:
                begin
                    if (restart)
                    begin
                        state_q <= game_state_pkg::ST_FETCH;
                        level_q <= target_pkg::LVL_1;
                    end
                end
                default:
                begin
                    state_q <= game_state_pkg::ST_OFF;
                    level_q <= target_pkg::LVL_NONE;
                end
            endcase
        end
    end

    // round target captured on the pop
    always_ff @(posedge clk)
    begin
        if (timer_load)
            target_q <= pull.target;
    end

    // beeper hold that power off cuts short
    always_ff @(posedge clk or posedge sw)
    begin
        if (sw)
            beep_cnt_q <= '0;
        else if (!enable)
            beep_cnt_q <= '0;
        else if (judge_fail)
            beep_cnt_q <= BW'(`BEEP_CYCLES);
        else if (beep_cnt_q != '0)
            beep_cnt_q <= beep_cnt_q - 1'b1;
    end

    a_led_mask: assert property (@(posedge clk) disable iff (sw)
        (led[15:7] == '0) && ((led[6:0] >> target_pkg::level_width(level_q)) == '0))
        else $error("led shows bits above the level width");

    a_quiet_off: assert property (@(posedge clk) disable iff (sw)
        (state_q == game_state_pkg::ST_OFF) |-> !beep)
        else $error("beep active while powered off");

endmodule

`default_nettype wire

/* rtl/memory_game_top.sv */
`timescale 1ns/1ps
`default_nettype none

module memory_game_top
(
    input  wire         clk,
    input  wire         sw,
    input  wire         enable,
    input  wire         start,
    input  wire         restart,
    input  wire  [6:0]  guess,
    output logic [15:0] led,
    output logic [1:0]  level,
    output logic [3:0]  countdown,
    output logic        beep,
    output logic        victory
);

    logic                push_valid;
    logic                push_ready;
    target_pkg::target_t push_target;
    logic                timer_load;
    logic                timer_expired;

    // buffer to controller stream
    target_if tgt_if ();

    target_lfsr u_lfsr
    (
        .clk         (clk),
        .sw          (sw),
        .push_valid  (push_valid),
        .push_ready  (push_ready),
        .push_target (push_target)
    );

    target_fifo u_fifo
    (
        .clk         (clk),
        .sw          (sw),
        .push_valid  (push_valid),
        .push_ready  (push_ready),
        .push_target (push_target),
        .pop         (tgt_if.buffer)
    );

    game_fsm u_fsm
    (
        .clk           (clk),
        .sw            (sw),
        .enable        (enable),
        .start         (start),
        .restart       (restart),
        .guess         (guess),
        .pull          (tgt_if.consumer),
        .timer_load    (timer_load),
        .timer_expired (timer_expired),
        .led           (led),
        .level         (level),
        .beep          (beep),
        .victory       (victory)
    );

    round_timer u_timer
    (
        .clk     (clk),
        .sw      (sw),
        .load    (timer_load),
        .count   (countdown),
        .expired (timer_expired)
    );

endmodule

`default_nettype wire

/* verif/tb_clk_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen
#(
    parameter int PERIOD_NS = 20
)
(
    output logic clk,
    output logic sw
);

    initial
    begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    // reset over two rising edges, released on a falling edge
    initial
    begin
        sw = 1'b1;
        repeat (2) @(posedge clk);
        @(negedge clk);
        sw = 1'b0;
    end

endmodule

`default_nettype wire

/* verif/tb_memory_game.sv */
`timescale 1ns/1ps
`default_nettype none

`include "game_defines.svh"

module tb_memory_game;

    localparam int CLK_PERIOD_NS = 20;
    localparam int SHOW_CYCLES   = `COUNT_START * `TICKS_PER_STEP;
    localparam int NUM_ROWS      = 15;
    localparam int WATCHDOG_NS   =
        NUM_ROWS * (SHOW_CYCLES + `BEEP_CYCLES + 64) * CLK_PERIOD_NS;

    typedef enum logic [1:0]
    {
        ACT_RIGHT,
        ACT_WRONG,
        ACT_RESTART,
        ACT_POWER
    } action_e;

    typedef struct packed
    {
        action_e            act;
        target_pkg::level_e level;
        logic               beep;
        logic               victory;
    } row_t;

    // action, level afterwards, beep expected, victory expected
    localparam row_t ROWS [NUM_ROWS] = '{
        '{ACT_RIGHT,   target_pkg::LVL_2, 1'b0, 1'b0},
        '{ACT_WRONG,   target_pkg::LVL_2, 1'b1, 1'b0},
        '{ACT_RIGHT,   target_pkg::LVL_3, 1'b0, 1'b0},
        '{ACT_WRONG,   target_pkg::LVL_3, 1'b1, 1'b0},
        '{ACT_RIGHT,   target_pkg::LVL_3, 1'b0, 1'b1},
        '{ACT_RESTART, target_pkg::LVL_1, 1'b0, 1'b0},
        '{ACT_RIGHT,   target_pkg::LVL_2, 1'b0, 1'b0},
        '{ACT_RESTART, target_pkg::LVL_1, 1'b0, 1'b0},
        '{ACT_POWER,   target_pkg::LVL_1, 1'b0, 1'b0},
        '{ACT_WRONG,   target_pkg::LVL_1, 1'b1, 1'b0},
        '{ACT_RIGHT,   target_pkg::LVL_2, 1'b0, 1'b0},
        '{ACT_RIGHT,   target_pkg::LVL_3, 1'b0, 1'b0},
        '{ACT_RIGHT,   target_pkg::LVL_3, 1'b0, 1'b1},
        '{ACT_RESTART, target_pkg::LVL_1, 1'b0, 1'b0},
        '{ACT_RIGHT,   target_pkg::LVL_2, 1'b0, 1'b0}
    };

    logic                clk;
    logic                sw;
    logic                enable;
    logic                start;
    logic                restart;
    target_pkg::target_t guess;
    logic [15:0]         led;
    logic [1:0]          level;
    logic [3:0]          countdown;
    logic                beep;
    logic                victory;

    integer              seed = 32'h3119;
    int                  errors = 0;
    // cycles of beep still expected
    int                  beep_left = 0;
    logic                exact_model;
    target_pkg::target_t model_lfsr;
    target_pkg::level_e  cur_level;
    logic                in_win;

    tb_clk_gen #(.PERIOD_NS(CLK_PERIOD_NS)) clk_gen
    (
        .clk (clk),
        .sw  (sw)
    );

    memory_game_top dut
    (
        .clk       (clk),
        .sw        (sw),
        .enable    (enable),
        .start     (start),
        .restart   (restart),
        .guess     (guess),
        .led       (led),
        .level     (level),
        .countdown (countdown),
        .beep      (beep),
        .victory   (victory)
    );

    task automatic abort_run();
        $display("test failed");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_led(input string name, input logic [15:0] got,
                             input logic [15:0] exp);
        if (got !== exp)
        begin
            $display("ERROR %s: got 0x%h, expected 0x%h", name, got, exp);
            errors++;
            abort_run();
        end
    endtask

    task automatic check_level(input string name, input target_pkg::level_e got,
                               input target_pkg::level_e exp);
        if (got !== exp)
        begin
            $display("ERROR %s: got 0x%h, expected 0x%h", name, got, exp);
            errors++;
            abort_run();
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp)
        begin
            $display("ERROR %s: got 0x%h, expected 0x%h", name, got, exp);
            errors++;
            abort_run();
        end
    endtask

    task automatic check_countdown(input string name, input logic [3:0] got,
                                   input logic [3:0] exp);
        if (got !== exp)
        begin
            $display("ERROR %s: got 0x%h, expected 0x%h", name, got, exp);
            errors++;
            abort_run();
        end
    endtask

    // compared bits per level are 5, 6 or 7
    function automatic target_pkg::target_t level_mask(target_pkg::level_e lvl);
        case (lvl)
            target_pkg::LVL_1: return 7'h1F;
            target_pkg::LVL_2: return 7'h3F;
            target_pkg::LVL_3: return 7'h7F;
            default:           return 7'h00;
        endcase
    endfunction

    // reference lfsr for x^7 + x^6 + 1 stepped once per pop
    function automatic target_pkg::target_t model_pop();
        target_pkg::target_t t;
        t          = model_lfsr;
        model_lfsr = {model_lfsr[5:0], model_lfsr[6] ^ model_lfsr[5]};
        return t;
    endfunction

    // every falling edge also checks the beeper hold
    task automatic tick();
        @(negedge clk);
        check_flag("beep", beep, beep_left != 0);
        if (beep_left != 0)
            beep_left--;
    endtask

    task automatic observe_show(output target_pkg::target_t shown);
        target_pkg::target_t mask;
        logic [15:0]         first_led;
        tick();
        while (countdown == 4'h0)
            tick();
        mask = level_mask(cur_level);
        if (exact_model)
        begin
            shown = model_pop();
            check_led("led", led, {9'b0, shown & mask});
        end
        else
        begin
            // after a flush only the mask rule holds
            check_led("led outside level width", led & ~{9'b0, mask}, 16'h0000);
            shown = led[6:0];
        end
        first_led = led;
        for (int i = 0; i < SHOW_CYCLES; i++)
        begin
            if (i != 0)
                tick();
            check_countdown("countdown", countdown,
                            4'(`COUNT_START - i / `TICKS_PER_STEP));
            check_led("led", led, first_led);
        end
        tick();
        check_countdown("countdown", countdown, 4'h0);
        check_led("led", led, 16'h0000);
    endtask

    task automatic press_start(input target_pkg::target_t value, input logic beep_exp);
        int delay;
        delay = {$random(seed)} % 4;
        repeat (delay) tick();
        guess = value;
        start = 1'b1;
        tick();
        start     = 1'b0;
        beep_left = beep_exp ? `BEEP_CYCLES : 0;
        tick();
    endtask

    task automatic pulse_restart();
        restart = 1'b1;
        tick();
        restart = 1'b0;
    endtask

    task automatic power_up();
        enable = 1'b1;
        tick();
        start = 1'b1;
        tick();
        start = 1'b0;
    endtask

    task automatic power_cycle();
        target_pkg::target_t lost;
        // power drops in the middle of a memorize phase
        if (!in_win)
        begin
            tick();
            while (countdown == 4'h0)
                tick();
            if (exact_model)
            begin
                lost = model_pop();
                check_led("led", led, {9'b0, lost & level_mask(cur_level)});
            end
        end
        enable = 1'b0;
        tick();
        check_level("level", target_pkg::level_e'(level), target_pkg::LVL_NONE);
        check_led("led", led, 16'h0000);
        check_flag("victory", victory, 1'b0);
        tick();
        exact_model = 1'b0;
        power_up();
    endtask

    initial
    begin
        target_pkg::target_t shown;
        enable      = 1'b0;
        start       = 1'b0;
        restart     = 1'b0;
        guess       = '0;
        exact_model = 1'b1;
        model_lfsr  = `LFSR_SEED;
        cur_level   = target_pkg::LVL_NONE;
        in_win      = 1'b0;

        wait (sw === 1'b1);
        wait (sw === 1'b0);
        tick();
        check_led("led", led, 16'h0000);
        check_level("level", target_pkg::level_e'(level), target_pkg::LVL_NONE);
        check_flag("victory", victory, 1'b0);
        check_countdown("countdown", countdown, 4'h0);

        power_up();
        check_level("level", target_pkg::level_e'(level), target_pkg::LVL_1);
        cur_level = target_pkg::LVL_1;

        for (int r = 0; r < NUM_ROWS; r++)
        begin
            if (!in_win && ROWS[r].act != ACT_POWER)
                observe_show(shown);
            case (ROWS[r].act)
                ACT_RIGHT:   press_start(shown, ROWS[r].beep);
                ACT_WRONG:   press_start(shown ^ 7'h01, ROWS[r].beep);
                ACT_RESTART: pulse_restart();
                default:     power_cycle();
            endcase
            check_level("level", target_pkg::level_e'(level), ROWS[r].level);
            check_flag("victory", victory, ROWS[r].victory);
            check_flag("beep", beep, ROWS[r].beep);
            cur_level = ROWS[r].level;
            in_win    = ROWS[r].victory;
        end

        if (errors == 0)
        begin
            $display("test passed");
            $finish;
        end
        else
        begin
            abort_run();
        end
    end

    // bound on the whole table run
    initial
    begin
        #(WATCHDOG_NS);
        $display("watchdog expired after %0d ns, the game stopped making progress",
                 WATCHDOG_NS);
        abort_run();
    end

endmodule

`default_nettype wire

/* vlog.f */
+incdir+rtl
rtl/target_pkg.sv
rtl/game_state_pkg.sv
rtl/target_if.sv
rtl/target_lfsr.sv
rtl/target_fifo.sv
rtl/round_timer.sv
rtl/game_fsm.sv
rtl/memory_game_top.sv
verif/tb_clk_gen.sv
verif/tb_memory_game.sv

/* run_sim.sh */
#!/bin/sh
# build the memory game testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f vlog.f --top-module tb_memory_game \
    -Mdir obj_dir -o sim_memory_game \
    && ./obj_dir/sim_memory_game \
    || exit 1
